// ==== source/l2_cache_pkg.sv ====
// L2 cache shared types
`default_nettype none

package l2_cache_pkg;
	// Cache geometry
	localparam int L2_NUM_WAYS = 4;
	localparam int L2_NUM_SETS = 16;
	localparam int LINE_BYTES = 16;

	// Line address, tag in the upper bits and set index in the lower bits
	typedef logic [15:0] line_addr_t;
	typedef logic [$clog2(L2_NUM_SETS)-1:0] set_index_t;
	typedef logic [$bits(line_addr_t)-$bits(set_index_t)-1:0] l2_tag_t;
	typedef logic [$clog2(L2_NUM_WAYS)-1:0] l2_way_t;
	// Data memory address, way above set
	typedef logic [$bits(l2_way_t)+$bits(set_index_t)-1:0] cache_index_t;
	typedef logic [LINE_BYTES*8-1:0] line_data_t;
	typedef logic [LINE_BYTES-1:0] byte_mask_t;
	// Two cores of four strands each
	typedef logic [2:0] strand_id_t;

	typedef enum logic [2:0]
	{
		LOAD,
		STORE,
		LOAD_SYNC,
		STORE_SYNC,
		FLUSH
	} l2_op_t;

	// Request from a core, or a fill carrying the line from memory
	typedef struct packed
	{
		logic valid;
		l2_op_t op;
		strand_id_t strand;
		line_addr_t address;
		logic is_fill;
		byte_mask_t store_mask;
		line_data_t store_data;
		line_data_t fill_data;
	} l2_request_t;

	typedef struct packed
	{
		logic valid;
		l2_op_t op;
		strand_id_t strand;
		line_addr_t address;
		logic hit;
		line_data_t data;
		logic sync_success;
	} l2_response_t;

	// Dirty line going back to memory
	typedef struct packed
	{
		logic valid;
		line_addr_t address;
		line_data_t data;
	} l2_writeback_t;

	// Directory stage result, dirty bits of every way in the set
	typedef struct packed
	{
		l2_request_t request;
		logic cache_hit;
		l2_way_t hit_way;
		l2_way_t fill_way;
		l2_tag_t old_tag;
		logic [L2_NUM_WAYS-1:0] victim_dirty;
	} dir_result_t;

	// Read stage result
	typedef struct packed
	{
		l2_request_t request;
		logic cache_hit;
		cache_index_t cache_index;
		l2_tag_t old_tag;
		logic line_is_dirty;
		logic store_sync_success;
	} read_result_t;
endpackage

`default_nettype wire

// ==== source/sram_1r1w.sv ====
// Dual port storage array
`default_nettype none
`timescale 1ns/100ps

module sram_1r1w
#(
	parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64
)
(
	input wire clk,
	input wire [$clog2(SIZE)-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data,
	input wire wr_enable,
	input wire [$clog2(SIZE)-1:0] wr_addr,
	input wire [DATA_WIDTH-1:0] wr_data
);
	logic [DATA_WIDTH-1:0] mem [SIZE];

	// Read every cycle, one cycle of latency
	// Same-cycle write is not visible on the read port
	always_ff @(posedge clk)
	begin
		if (wr_enable)
			mem[wr_addr] <= wr_data;

		rd_data <= mem[rd_addr];
	end
endmodule

`default_nettype wire

// ==== source/l2_cache_dir.sv ====
// L2 cache directory stage
`default_nettype none
`timescale 1ns/100ps

module l2_cache_dir
(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::l2_request_t request,
	output l2_cache_pkg::dir_result_t dir_out
);
	import l2_cache_pkg::*;

	set_index_t req_set;
	l2_tag_t req_tag;
	logic store_op;

	// Per way and set directory state
	l2_tag_t tag_array [L2_NUM_WAYS][L2_NUM_SETS];
	logic [L2_NUM_WAYS-1:0] line_valid [L2_NUM_SETS];
	logic [L2_NUM_WAYS-1:0] line_dirty [L2_NUM_SETS];
	// Round-robin replacement pointer per set
	l2_way_t replace_way [L2_NUM_SETS];

	logic [L2_NUM_WAYS-1:0] way_hit;
	logic cache_hit;
	l2_way_t hit_way;
	l2_way_t fill_way;

	assign req_set = request.address[$bits(set_index_t)-1:0];
	assign req_tag = request.address[$bits(line_addr_t)-1:$bits(set_index_t)];
	assign store_op = request.op == STORE || request.op == STORE_SYNC;

	// Tag compare against all ways of the set
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < L2_NUM_WAYS; w++)
		begin
			way_hit[w] = line_valid[req_set][w] && tag_array[w][req_set] == req_tag;
			if (way_hit[w])
				hit_way = l2_way_t'(w);
		end
	end

	assign cache_hit = |way_hit;

	// Victim choice, lowest invalid way wins over the pointer
	always_comb
	begin
		fill_way = replace_way[req_set];
		for (int w = L2_NUM_WAYS - 1; w >= 0; w--)
		begin
			if (!line_valid[req_set][w])
				fill_way = l2_way_t'(w);
		end
	end

	// Install new tag on fill
	always_ff @(posedge clk)
	begin
		if (request.valid && request.is_fill)
			tag_array[fill_way][req_set] <= req_tag;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < L2_NUM_SETS; s++)
			begin
				line_valid[s] <= '0;
				line_dirty[s] <= '0;
				replace_way[s] <= '0;
			end
		end
		else if (request.valid)
		begin
			if (request.is_fill)
			begin
				line_valid[req_set][fill_way] <= 1'b1;
				// Store fills start dirty
				line_dirty[req_set][fill_way] <= store_op;
				replace_way[req_set] <= replace_way[req_set] + l2_way_t'(1);
			end
			else if (cache_hit)
			begin
				// Store sync success unknown here, so any hitting one marks dirty
				if (store_op)
					line_dirty[req_set][hit_way] <= 1'b1;
				else if (request.op == FLUSH)
					line_dirty[req_set][hit_way] <= 1'b0;
			end
		end
	end

	// Stage register, dirty bits taken before this request's update
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dir_out.request.valid <= 1'b0;
		else
		begin
			dir_out.request <= request;
			dir_out.cache_hit <= cache_hit;
			dir_out.hit_way <= hit_way;
			dir_out.fill_way <= fill_way;
			dir_out.old_tag <= tag_array[fill_way][req_set];
			dir_out.victim_dirty <= line_dirty[req_set];
		end
	end
endmodule

`default_nettype wire

// ==== source/l2_cache_read.sv ====
// L2 cache data read stage
`default_nettype none
`timescale 1ns/100ps

module l2_cache_read
#(
	parameter int NUM_STRANDS = 8
)
(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::dir_result_t dir_out,
	input wire update_enable,
	input wire l2_cache_pkg::cache_index_t update_index,
	input wire l2_cache_pkg::line_data_t update_data,
	output l2_cache_pkg::read_result_t read_out,
	output l2_cache_pkg::line_data_t rd_cache_mem_result
);
	import l2_cache_pkg::*;

	set_index_t req_set;
	cache_index_t read_index;
	logic line_is_dirty;
	logic line_present;
	logic store_sync_success;

	// One reservation per strand
	line_addr_t resv_addr [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] resv_valid;

	assign req_set = dir_out.request.address[$bits(set_index_t)-1:0];

	// Fill reads the victim line for writeback, otherwise the hit line
	assign read_index = dir_out.request.is_fill ? {dir_out.fill_way, req_set}
		: {dir_out.hit_way, req_set};

	sram_1r1w #(
		.DATA_WIDTH($bits(line_data_t)),
		.SIZE(L2_NUM_WAYS * L2_NUM_SETS)
	) cache_mem (
		.clk(clk),
		.rd_addr(read_index),
		.rd_data(rd_cache_mem_result),
		.wr_enable(update_enable),
		.wr_addr(update_index),
		.wr_data(update_data)
	);

	// Flush looks at the hit way, a fill at the way being replaced
	assign line_is_dirty = dir_out.victim_dirty[dir_out.request.op == FLUSH
		? dir_out.hit_way : dir_out.fill_way];

	// Line is in the cache after this request
	assign line_present = dir_out.request.valid && (dir_out.cache_hit || dir_out.request.is_fill);

	assign store_sync_success = line_present
		&& dir_out.request.op == STORE_SYNC
		&& resv_valid[dir_out.request.strand]
		&& resv_addr[dir_out.request.strand] == dir_out.request.address;

	always_ff @(posedge clk)
	begin
		if (line_present && dir_out.request.op == LOAD_SYNC)
			resv_addr[dir_out.request.strand] <= dir_out.request.address;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resv_valid <= '0;
		else if (line_present)
		begin
			if (dir_out.request.op == LOAD_SYNC)
				resv_valid[dir_out.request.strand] <= 1'b1;
			else if (dir_out.request.op == STORE || store_sync_success)
			begin
				// Failed store sync leaves reservations alone to avoid livelock
				for (int k = 0; k < NUM_STRANDS; k++)
				begin
					if (resv_addr[k] == dir_out.request.address)
						resv_valid[k] <= 1'b0;
				end
			end
		end
	end

	// Stage register, aligned with the memory output
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_out.request.valid <= 1'b0;
		else
		begin
			read_out.request <= dir_out.request;
			read_out.cache_hit <= dir_out.cache_hit;
			read_out.cache_index <= read_index;
			read_out.old_tag <= dir_out.old_tag;
			read_out.line_is_dirty <= line_is_dirty;
			read_out.store_sync_success <= store_sync_success;
		end
	end
endmodule

`default_nettype wire

// ==== source/l2_cache_update.sv ====
// L2 cache update stage
`default_nettype none
`timescale 1ns/100ps

module l2_cache_update
(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::read_result_t read_out,
	input wire l2_cache_pkg::line_data_t rd_cache_mem_result,
	output logic update_enable,
	output l2_cache_pkg::cache_index_t update_index,
	output l2_cache_pkg::line_data_t update_data,
	output l2_cache_pkg::l2_response_t response,
	output l2_cache_pkg::l2_writeback_t writeback
);
	import l2_cache_pkg::*;

	// Last write, memory read port misses it for one cycle
	logic last_valid;
	cache_index_t last_index;
	line_data_t last_data;

	set_index_t req_set;
	line_data_t old_line;
	line_data_t base_line;
	line_data_t merged_line;
	logic line_present;
	logic do_store;
	logic dirty_evict;
	logic dirty_flush;

	assign req_set = read_out.request.address[$bits(set_index_t)-1:0];
	assign old_line = last_valid && last_index == read_out.cache_index ? last_data
		: rd_cache_mem_result;
	assign base_line = read_out.request.is_fill ? read_out.request.fill_data : old_line;
	assign line_present = read_out.cache_hit || read_out.request.is_fill;
	assign do_store = (line_present && read_out.request.op == STORE)
		|| read_out.store_sync_success;

	// Byte merge of store data
	always_comb
	begin
		merged_line = base_line;
		if (do_store)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (read_out.request.store_mask[b])
					merged_line[b*8 +: 8] = read_out.request.store_data[b*8 +: 8];
			end
		end
	end

	assign update_enable = read_out.request.valid && (read_out.request.is_fill || do_store);
	assign update_index = read_out.cache_index;
	assign update_data = merged_line;

	assign dirty_evict = read_out.request.is_fill && read_out.line_is_dirty;
	assign dirty_flush = read_out.request.op == FLUSH && read_out.cache_hit
		&& read_out.line_is_dirty;

	always_ff @(posedge clk)
	begin
		last_index <= update_index;
		last_data <= update_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			last_valid <= 1'b0;
			response.valid <= 1'b0;
			writeback.valid <= 1'b0;
		end
		else
		begin
			last_valid <= update_enable;
			response.valid <= read_out.request.valid;
			response.op <= read_out.request.op;
			response.strand <= read_out.request.strand;
			response.address <= read_out.request.address;
			response.hit <= line_present;
			response.data <= merged_line;
			response.sync_success <= read_out.store_sync_success;
			writeback.valid <= read_out.request.valid && (dirty_evict || dirty_flush);
			// Evicted line goes back under its old tag
			writeback.address <= read_out.request.is_fill ? {read_out.old_tag, req_set}
				: read_out.request.address;
			writeback.data <= old_line;
		end
	end
endmodule

`default_nettype wire

// ==== source/l2_cache_pipeline.sv ====
// L2 cache pipeline top
`default_nettype none
`timescale 1ns/100ps

module l2_cache_pipeline
#(
	parameter int NUM_STRANDS = 8
)
(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::l2_request_t request,
	output l2_cache_pkg::l2_response_t response,
	output l2_cache_pkg::l2_writeback_t writeback
);
	import l2_cache_pkg::*;

	// Stage to stage bundles
	dir_result_t dir_out;
	read_result_t read_out;
	line_data_t rd_cache_mem_result;

	// Cache write port, driven by update
	logic update_enable;
	cache_index_t update_index;
	line_data_t update_data;

	l2_cache_dir u_dir (
		.clk(clk),
		.reset(reset),
		.request(request),
		.dir_out(dir_out)
	);

	l2_cache_read #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_read (
		.clk(clk),
		.reset(reset),
		.dir_out(dir_out),
		.update_enable(update_enable),
		.update_index(update_index),
		.update_data(update_data),
		.read_out(read_out),
		.rd_cache_mem_result(rd_cache_mem_result)
	);

	l2_cache_update u_update (
		.clk(clk),
		.reset(reset),
		.read_out(read_out),
		.rd_cache_mem_result(rd_cache_mem_result),
		.update_enable(update_enable),
		.update_index(update_index),
		.update_data(update_data),
		.response(response),
		.writeback(writeback)
	);
endmodule

`default_nettype wire

// ==== testbench/l2_cache_props.sv ====
// L2 cache pipeline properties
`default_nettype none
`timescale 1ns/100ps

module l2_cache_props
(
	input wire clk,
	input wire reset,
	input wire l2_cache_pkg::l2_request_t request,
	input wire l2_cache_pkg::l2_response_t response,
	input wire l2_cache_pkg::l2_writeback_t writeback
);
	import l2_cache_pkg::*;

	// Failed assertions so far, read by the testbench
	int unsigned assert_errors = 0;

	// Fixed latency of three cycles
	response_latency: assert property (@(posedge clk) disable iff (reset)
		response.valid == $past(request.valid, 3))
	else
	begin
		assert_errors++;
		$error("response valid not three cycles after request valid");
	end

	// Writeback only alongside a fill or flush response
	writeback_source: assert property (@(posedge clk) disable iff (reset)
		writeback.valid |-> response.valid
			&& (response.op == FLUSH || $past(request.is_fill, 3)))
	else
	begin
		assert_errors++;
		$error("writeback without a fill or flush response");
	end

	// Quiet outputs while reset is held and in the cycle after
	reset_quiet: assert property (@(posedge clk)
		(reset && $past(reset)) || $fell(reset) |-> !response.valid && !writeback.valid)
	else
	begin
		assert_errors++;
		$error("output strobe during or right after reset");
	end

	// Consecutive responses need two matching requests
	response_pairing: assert property (@(posedge clk) disable iff (reset)
		response.valid && $past(response.valid) |->
			response.address == $past(request.address, 3)
			&& $past(response.address) == $past(request.address, 4))
	else
	begin
		assert_errors++;
		$error("back-to-back responses do not match their requests");
	end
endmodule

bind l2_cache_pipeline l2_cache_props u_props (
	.clk(clk),
	.reset(reset),
	.request(request),
	.response(response),
	.writeback(writeback)
);

`default_nettype wire

// ==== testbench/l2_cache_tb.sv ====
// L2 cache pipeline testbench
`default_nettype none
`timescale 1ns/100ps

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int LATENCY = 3;
	// Requests over all tests including the random section
	localparam int NUM_RANDOM = 24;
	localparam int NUM_REQUESTS = 28 + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (LATENCY + 4) + 4 * RESET_CYCLES + 50;

	logic clk;
	logic reset;
	l2_request_t request;
	l2_response_t response;
	l2_writeback_t writeback;

	// Model of the cache contents
	l2_tag_t m_tag [L2_NUM_WAYS][L2_NUM_SETS];
	logic m_valid [L2_NUM_WAYS][L2_NUM_SETS];
	logic m_dirty [L2_NUM_WAYS][L2_NUM_SETS];
	line_data_t m_data [L2_NUM_WAYS][L2_NUM_SETS];
	l2_way_t m_rr [L2_NUM_SETS];
	// Reservations per strand
	line_addr_t m_resv_addr [8];
	logic m_resv_valid [8];
	// Main memory holding only the lines written back
	line_data_t main_mem [line_addr_t];

	// Expected results in issue order
	l2_response_t exp_resp [$];
	l2_writeback_t exp_wb [$];
	string exp_name [$];

	logic [15:0] lfsr_state;
	int errors;

	l2_cache_pipeline #(
		.NUM_STRANDS(8)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.request(request),
		.response(response),
		.writeback(writeback)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [127:0] random_bits(input int n);
		logic [127:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[126:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic line_data_t mem_line(input line_addr_t addr);
		if (main_mem.exists(addr))
			return main_mem[addr];
		// Untouched line gets a pattern from the whole address
		return {4{addr, addr ^ 16'hC3A5}};
	endfunction

	task automatic clear_model();
		for (int s = 0; s < L2_NUM_SETS; s++)
		begin
			m_rr[s] = '0;
			for (int w = 0; w < L2_NUM_WAYS; w++)
			begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
			end
		end
		for (int k = 0; k < 8; k++)
			m_resv_valid[k] = 1'b0;
	endtask

	// Drive one request and predict its response
	task automatic issue(input string name, input l2_op_t op, input strand_id_t strand,
		input line_addr_t addr, input logic fill, input byte_mask_t mask,
		input line_data_t sdata);
		l2_request_t req;
		l2_response_t resp;
		l2_writeback_t wb;
		set_index_t idx;
		int way;
		logic hit;
		logic success;
		line_data_t line;
		idx = addr[3:0];
		req = '{valid: 1'b1, op: op, strand: strand, address: addr, is_fill: fill,
			store_mask: mask, store_data: sdata, fill_data: fill ? mem_line(addr) : '0};
		@(posedge clk);
		request <= req;
		wb = '0;
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < L2_NUM_WAYS; w++)
		begin
			if (m_valid[w][idx] && m_tag[w][idx] == addr[15:4])
			begin
				hit = 1'b1;
				way = w;
			end
		end
		if (fill)
		begin
			// Lowest invalid way or else the round-robin way
			way = m_rr[idx];
			for (int w = L2_NUM_WAYS - 1; w >= 0; w--)
			begin
				if (!m_valid[w][idx])
					way = w;
			end
			if (m_dirty[way][idx])
			begin
				wb = '{valid: 1'b1, address: {m_tag[way][idx], idx}, data: m_data[way][idx]};
				main_mem[wb.address] = wb.data;
			end
			m_tag[way][idx] = addr[15:4];
			m_valid[way][idx] = 1'b1;
			m_dirty[way][idx] = op == STORE || op == STORE_SYNC;
			m_data[way][idx] = req.fill_data;
			m_rr[idx] = m_rr[idx] + 1'b1;
		end
		line = (hit || fill) ? m_data[way][idx] : '0;
		success = (hit || fill) && op == STORE_SYNC && m_resv_valid[strand]
			&& m_resv_addr[strand] == addr;
		if ((hit || fill) && (op == STORE || success))
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (mask[b])
					line[b*8 +: 8] = sdata[b*8 +: 8];
			end
			m_data[way][idx] = line;
		end
		if (hit && !fill)
		begin
			if (op == STORE || op == STORE_SYNC)
				m_dirty[way][idx] = 1'b1;
			else if (op == FLUSH)
			begin
				if (m_dirty[way][idx])
				begin
					wb = '{valid: 1'b1, address: addr, data: line};
					main_mem[addr] = line;
				end
				m_dirty[way][idx] = 1'b0;
			end
		end
		if (hit || fill)
		begin
			if (op == LOAD_SYNC)
			begin
				m_resv_addr[strand] = addr;
				m_resv_valid[strand] = 1'b1;
			end
			else if (op == STORE || success)
			begin
				for (int k = 0; k < 8; k++)
				begin
					if (m_resv_addr[k] == addr)
						m_resv_valid[k] = 1'b0;
				end
			end
		end
		resp = '{valid: 1'b1, op: op, strand: strand, address: addr, hit: hit || fill,
			data: line, sync_success: success};
		exp_resp.push_back(resp);
		exp_wb.push_back(wb);
		exp_name.push_back(name);
	endtask

	// End the burst and wait for every response
	task automatic drain();
		@(posedge clk);
		request.valid <= 1'b0;
		while (exp_resp.size() != 0)
			@(posedge clk);
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic compare_response(input string name, input l2_response_t exp_r,
		input l2_writeback_t exp_w);
		check_value({name, " op"}, exp_r.op, response.op);
		check_value({name, " strand"}, exp_r.strand, response.strand);
		check_value({name, " address"}, exp_r.address, response.address);
		check_value({name, " hit"}, exp_r.hit, response.hit);
		// Miss data is undefined
		if (exp_r.hit)
			check_value({name, " data"}, exp_r.data, response.data);
		if (exp_r.op == STORE_SYNC)
			check_value({name, " sync"}, exp_r.sync_success, response.sync_success);
		check_value({name, " writeback"}, exp_w.valid, writeback.valid);
		if (exp_w.valid && writeback.valid)
		begin
			check_value({name, " wb address"}, exp_w.address, writeback.address);
			check_value({name, " wb data"}, exp_w.data, writeback.data);
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (!reset && response.valid)
		begin
			if (exp_resp.size() == 0)
			begin
				errors++;
				$display("A response arrived with no request outstanding");
			end
			else
				compare_response(exp_name.pop_front(), exp_resp.pop_front(), exp_wb.pop_front());
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles with responses still missing",
			WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		line_addr_t addr_a;
		line_addr_t addr_b;
		line_addr_t rand_addr [4];
		strand_id_t s1;
		byte_mask_t mask;
		line_data_t data;
		l2_op_t op;
		clk = 1'b0;
		reset = 1'b1;
		request = '0;
		errors = 0;
		lfsr_state = 16'd21395;
		addr_a = 16'h1230;
		addr_b = 16'h2341;
		rand_addr = '{16'h0A13, 16'h0B13, 16'h0C13, 16'h0D13};
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// Miss, fill from memory, then a hit
		issue("miss_fill load", LOAD, 3'd0, addr_a, 1'b0, '0, '0);
		drain();
		issue("miss_fill fill", LOAD, 3'd0, addr_a, 1'b1, '0, '0);
		issue("miss_fill reload", LOAD, 3'd0, addr_a, 1'b0, '0, '0);
		drain();

		// Store then a load in the very next cycle
		s1 = random_bits(3);
		mask = random_bits(16);
		data = random_bits(128);
		issue("store_fwd store", STORE, s1, addr_a, 1'b0, mask, data);
		issue("store_fwd load", LOAD, s1, addr_a, 1'b0, '0, '0);
		drain();

		// Reservations with a foreign store in between
		s1 = random_bits(3);
		mask = random_bits(16);
		data = random_bits(128);
		issue("resv fill", LOAD, s1, addr_b, 1'b1, '0, '0);
		issue("resv load_sync", LOAD_SYNC, s1, addr_b, 1'b0, '0, '0);
		issue("resv store_sync ok", STORE_SYNC, s1, addr_b, 1'b0, mask, data);
		issue("resv load_sync again", LOAD_SYNC, s1, addr_b, 1'b0, '0, '0);
		issue("resv foreign store", STORE, s1 + 3'd1, addr_b, 1'b0, ~mask, ~data);
		issue("resv other load_sync", LOAD_SYNC, s1 + 3'd2, addr_b, 1'b0, '0, '0);
		issue("resv store_sync fail", STORE_SYNC, s1, addr_b, 1'b0, mask, data);
		issue("resv other store_sync", STORE_SYNC, s1 + 3'd2, addr_b, 1'b0, ~mask, data);
		issue("resv final load", LOAD, s1, addr_b, 1'b0, '0, '0);
		drain();

		// Six fills into set 2 evicting a dirty then a clean victim
		for (int i = 0; i < 6; i++)
		begin
			op = (i % 2 == 0) ? STORE : LOAD;
			mask = random_bits(16);
			data = random_bits(128);
			issue("evict fill", op, 3'd1, {12'h100 + 12'(i), 4'h2}, 1'b1, mask, data);
		end
		drain();

		// Dirty flush, clean flush, then still a hit
		issue("flush dirty", FLUSH, 3'd2, addr_a, 1'b0, '0, '0);
		issue("flush clean", FLUSH, 3'd2, addr_a, 1'b0, '0, '0);
		issue("flush load", LOAD, 3'd2, addr_a, 1'b0, '0, '0);
		drain();

		// Random traffic on set 3 where the last address is never filled
		for (int i = 0; i < 3; i++)
			issue("random fill", LOAD, 3'd0, rand_addr[i], 1'b1, '0, '0);
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			op = l2_op_t'(random_bits(2));
			s1 = random_bits(3);
			mask = random_bits(16);
			data = random_bits(128);
			issue("random", op, s1, rand_addr[random_bits(2)], 1'b0, mask, data);
		end
		drain();

		// Reset mid-run so old lines miss
		@(posedge clk);
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		clear_model();
		repeat (4) @(posedge clk);
		issue("reset load a", LOAD, 3'd0, addr_a, 1'b0, '0, '0);
		issue("reset load b", LOAD, 3'd0, addr_b, 1'b0, '0, '0);
		drain();
		repeat (2) @(posedge clk);

		$display("Errors: %0d value mismatches, %0d assertion failures", errors,
			u_dut.u_props.assert_errors);
		if (errors == 0 && u_dut.u_props.assert_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

// ==== l2_cache.f ====
source/l2_cache_pkg.sv
source/sram_1r1w.sv
source/l2_cache_dir.sv
source/l2_cache_read.sv
source/l2_cache_update.sv
source/l2_cache_pipeline.sv
testbench/l2_cache_props.sv
testbench/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - source/l2_cache_pkg.sv
  - source/sram_1r1w.sv
  - source/l2_cache_dir.sv
  - source/l2_cache_read.sv
  - source/l2_cache_update.sv
  - source/l2_cache_pipeline.sv
  - target: test
    files:
      - testbench/l2_cache_props.sv
      - testbench/l2_cache_tb.sv
